//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  lc3b_types::lc3b_aluop aluop,
	input  lc3b_types::lc3b_word  a,
	input  lc3b_types::lc3b_word  b,
	output lc3b_types::lc3b_word  f
);
	import lc3b_types::*;

	logic [3:0] shamt;

	assign shamt = b[3:0]; // Only the low nibble counts for SHF

	always_comb begin
		case (aluop)
			alu_add:  f = a + b;
			alu_and:  f = a & b;
			alu_not:  f = ~a;
			alu_sll:  f = a << shamt;
			alu_srl:  f = a >> shamt;
			alu_sra:  f = lc3b_word'($signed(a) >>> shamt);
			default:  f = a;
		endcase
	end

endmodule : alu

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  lc3b_types::lc3b_word     sr1,
	input  lc3b_types::lc3b_word     sr2,
	input  lc3b_types::lc3b_word     pc,
	input  lc3b_types::lc3b_offset9  offset9,
	input  lc3b_types::lc3b_offset11 offset11,
	input  lc3b_types::lc3b_offset8  offset8,
	input  lc3b_types::lc3b_imm5     imm5,
	input  lc3b_types::lc3b_word     write_data,
	input  logic                     sr1_forward_sel,
	input  logic                     sr2_forward_sel,
	input  logic                     sr2mux_sel,
	input  logic                     bradd2mux_sel,
	input  lc3b_types::lc3b_aluop    aluop,
	input  logic [1:0]               result_sel,
	input  logic [1:0]               target_sel,
	output lc3b_types::lc3b_word     result,
	output lc3b_types::lc3b_word     target
);
	import lc3b_types::*;

	lc3b_word sr1_fwd;
	lc3b_word sr2_fwd;
	lc3b_word imm_sext;
	lc3b_word sr2mux_out;
	lc3b_word adj9;
	lc3b_word adj11;
	lc3b_word br_add_out;
	lc3b_word br_add2_out;
	lc3b_word bradd2mux_out;
	lc3b_word trap_vec;
	lc3b_word alu_out;

	assign sr1_fwd = sr1_forward_sel ? write_data : sr1; // WB value beats the stale read
	assign sr2_fwd = sr2_forward_sel ? write_data : sr2;

	assign imm_sext   = {{11{imm5[4]}}, imm5};
	assign sr2mux_out = sr2mux_sel ? imm_sext : sr2_fwd;

	// Offsets count words, so shift them into byte offsets
	assign adj9  = {{6{offset9[8]}}, offset9, 1'b0};
	assign adj11 = {{4{offset11[10]}}, offset11, 1'b0};

	assign br_add_out  = pc + adj9;
	assign br_add2_out = pc + adj11;

	assign bradd2mux_out = bradd2mux_sel ? sr1_fwd : br_add2_out; // JMP and JSRR take the base

	assign trap_vec = {7'b0, offset8, 1'b0};

	alu arith_unit (
		.aluop (aluop),
		.a     (sr1_fwd),
		.b     (sr2mux_out),
		.f     (alu_out)
	);

	always_comb begin
		case (result_sel)
			2'd0:    result = alu_out;
			2'd1:    result = br_add_out; // LEA
			default: result = pc;         // Link value for R7
		endcase
	end

	always_comb begin
		case (target_sel)
			2'd0:    target = br_add_out;
			2'd1:    target = bradd2mux_out;
			default: target = trap_vec;
		endcase
	end

endmodule : execute_stage

`default_nettype wire

//--- logic/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	input  lc3b_types::lc3b_word     in_instr,
	input  lc3b_types::lc3b_word     in_pc,
	input  lc3b_types::lc3b_word     rf_a,
	input  lc3b_types::lc3b_word     rf_b,
	output lc3b_types::lc3b_word     id_instr,
	output lc3b_types::lc3b_reg      src_a,
	output lc3b_types::lc3b_reg      src_b,
	output lc3b_types::lc3b_word     sr1,
	output lc3b_types::lc3b_word     sr2,
	output lc3b_types::lc3b_word     pc,
	output lc3b_types::lc3b_offset9  offset9,
	output lc3b_types::lc3b_offset11 offset11,
	output lc3b_types::lc3b_offset8  offset8,
	output lc3b_types::lc3b_imm5     imm5
);
	import lc3b_types::*;

	lc3b_word id_pc;

	// Reset value decodes as a BR with an empty mask
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_instr <= '0;
		end else if (in_valid) begin
			id_instr <= in_instr;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			id_pc <= in_pc;
		end
	end

	assign src_a = id_instr[8:6];
	assign src_b = id_instr[2:0];

	// ID/EX operand and field registers
	always_ff @(posedge clk) begin
		sr1      <= rf_a;
		sr2      <= rf_b;
		pc       <= id_pc;
		offset9  <= id_instr[8:0];
		offset11 <= id_instr[10:0];
		offset8  <= id_instr[7:0];
		imm5     <= id_instr[4:0];
	end

endmodule : id_stage

`default_nettype wire

//--- logic/lc3b_cfg.svh
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// Condition codes out of reset hold Z
`define LC3B_RESET_CC 3'b010

`define LC3B_LINK_REG 3'd7

// Cycles from in_valid to res_valid
`define LC3B_PIPE_DEPTH 3

`endif

//--- logic/lc3b_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_pipe (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 in_valid,
	input  lc3b_types::lc3b_word in_instr,
	input  lc3b_types::lc3b_word in_pc,
	output logic                 res_valid,
	output logic                 res_we,
	output lc3b_types::lc3b_reg  res_dest,
	output lc3b_types::lc3b_word res_data,
	output lc3b_types::lc3b_word res_target,
	output logic                 res_taken
);
	import lc3b_types::*;

	lc3b_word     id_instr, rf_a, rf_b, write_data;
	lc3b_reg      src_a, src_b, ex_dest;
	lc3b_word     sr1, sr2, pc, result, target;
	lc3b_offset9  offset9;
	lc3b_offset11 offset11;
	lc3b_offset8  offset8;
	lc3b_imm5     imm5;
	lc3b_aluop    ex_aluop;
	logic         sr2mux_sel, bradd2mux_sel;
	logic         sr1_forward_sel, sr2_forward_sel;
	logic [1:0]   result_sel, target_sel;
	logic         ex_valid, ex_we, ex_taken;

	pipe_control i_ctrl (
		.clk             (clk),
		.arst_n          (arst_n),
		.in_valid        (in_valid),
		.id_instr        (id_instr),
		.write_data      (write_data),
		.ex_aluop        (ex_aluop),
		.sr2mux_sel      (sr2mux_sel),
		.result_sel      (result_sel),
		.target_sel      (target_sel),
		.bradd2mux_sel   (bradd2mux_sel),
		.sr1_forward_sel (sr1_forward_sel),
		.sr2_forward_sel (sr2_forward_sel),
		.ex_valid        (ex_valid),
		.ex_we           (ex_we),
		.ex_dest         (ex_dest),
		.ex_taken        (ex_taken)
	);

	id_stage i_id (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.in_instr (in_instr),
		.in_pc    (in_pc),
		.rf_a     (rf_a),
		.rf_b     (rf_b),
		.id_instr (id_instr),
		.src_a    (src_a),
		.src_b    (src_b),
		.sr1      (sr1),
		.sr2      (sr2),
		.pc       (pc),
		.offset9  (offset9),
		.offset11 (offset11),
		.offset8  (offset8),
		.imm5     (imm5)
	);

	// Written from WB, read by the instruction in ID
	regfile i_rf (
		.clk    (clk),
		.arst_n (arst_n),
		.we     (res_we),
		.dest   (res_dest),
		.data   (write_data),
		.src_a  (src_a),
		.src_b  (src_b),
		.out_a  (rf_a),
		.out_b  (rf_b)
	);

	execute_stage i_ex (
		.sr1             (sr1),
		.sr2             (sr2),
		.pc              (pc),
		.offset9         (offset9),
		.offset11        (offset11),
		.offset8         (offset8),
		.imm5            (imm5),
		.write_data      (write_data),
		.sr1_forward_sel (sr1_forward_sel),
		.sr2_forward_sel (sr2_forward_sel),
		.sr2mux_sel      (sr2mux_sel),
		.bradd2mux_sel   (bradd2mux_sel),
		.aluop           (ex_aluop),
		.result_sel      (result_sel),
		.target_sel      (target_sel),
		.result          (result),
		.target          (target)
	);

	wb_stage i_wb (
		.clk        (clk),
		.arst_n     (arst_n),
		.ex_valid   (ex_valid),
		.ex_we      (ex_we),
		.ex_dest    (ex_dest),
		.ex_taken   (ex_taken),
		.result     (result),
		.target     (target),
		.write_data (write_data),
		.res_valid  (res_valid),
		.res_we     (res_we),
		.res_dest   (res_dest),
		.res_data   (res_data),
		.res_target (res_target),
		.res_taken  (res_taken)
	);

endmodule : lc3b_pipe

`default_nettype wire

//--- logic/lc3b_types.sv
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0]  lc3b_reg;

	typedef logic [8:0]  lc3b_offset9;
	typedef logic [10:0] lc3b_offset11;
	typedef logic [7:0]  lc3b_offset8;
	typedef logic [4:0]  lc3b_imm5;

	typedef logic [2:0]  lc3b_nzp; // N in bit 2, Z in bit 1, P in bit 0

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass,
		alu_sll,
		alu_srl,
		alu_sra
	} lc3b_aluop;

endpackage : lc3b_types

`default_nettype wire

//--- logic/pipe_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_cfg.svh"

module pipe_control (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_valid,
	input  lc3b_types::lc3b_word  id_instr,
	input  lc3b_types::lc3b_word  write_data,
	output lc3b_types::lc3b_aluop ex_aluop,
	output logic                  sr2mux_sel,
	output logic [1:0]            result_sel,
	output logic [1:0]            target_sel,
	output logic                  bradd2mux_sel,
	output logic                  sr1_forward_sel,
	output logic                  sr2_forward_sel,
	output logic                  ex_valid,
	output logic                  ex_we,
	output lc3b_types::lc3b_reg   ex_dest,
	output logic                  ex_taken
);
	import lc3b_types::*;

	function automatic lc3b_nzp gen_cc(input lc3b_word w);
		if (w[15])
			return 3'b100;
		else if (w == '0)
			return 3'b010;
		return 3'b001;
	endfunction

	lc3b_opcode opcode;
	logic       id_valid;

	logic       dec_we, dec_cc_we, dec_branch, dec_jump;
	logic       dec_sr2mux_sel, dec_bradd2_sel;
	logic [1:0] dec_result_sel, dec_target_sel;
	lc3b_aluop  dec_aluop;
	lc3b_reg    dec_dest;

	logic       ex_cc_we, ex_branch, ex_jump;
	lc3b_nzp    ex_mask;
	lc3b_reg    ex_src1, ex_src2;

	logic       wb_valid, wb_we, wb_cc_we;
	lc3b_reg    wb_dest;
	lc3b_nzp    cc_reg, cc_ex;

	assign opcode = lc3b_opcode'(id_instr[15:12]);

	always_comb begin
		dec_we         = 1'b0;
		dec_cc_we      = 1'b0;
		dec_branch     = 1'b0;
		dec_jump       = 1'b0;
		dec_sr2mux_sel = 1'b0;
		dec_bradd2_sel = 1'b0;
		dec_result_sel = 2'd0;
		dec_target_sel = 2'd0;
		dec_aluop      = alu_pass;
		dec_dest       = id_instr[11:9];
		case (opcode)
			op_add, op_and, op_not: begin
				dec_we         = 1'b1;
				dec_cc_we      = 1'b1;
				dec_sr2mux_sel = id_instr[5];
				dec_aluop      = (opcode == op_add) ? alu_add :
				                 (opcode == op_and) ? alu_and : alu_not;
			end
			op_shf: begin
				dec_we         = 1'b1;
				dec_cc_we      = 1'b1;
				dec_sr2mux_sel = 1'b1; // Shift amount rides in the immediate
				dec_aluop      = id_instr[4] ? alu_sll : (id_instr[5] ? alu_sra : alu_srl);
			end
			op_lea: begin
				dec_we         = 1'b1;
				dec_cc_we      = 1'b1;
				dec_result_sel = 2'd1;
			end
			op_br: dec_branch = 1'b1;
			op_jmp: begin
				dec_jump       = 1'b1;
				dec_target_sel = 2'd1;
				dec_bradd2_sel = 1'b1;
			end
			op_jsr: begin
				dec_jump       = 1'b1;
				dec_we         = 1'b1;
				dec_dest       = `LC3B_LINK_REG;
				dec_result_sel = 2'd2;
				dec_target_sel = 2'd1;
				dec_bradd2_sel = ~id_instr[11]; // Bit 11 clear means JSRR
			end
			op_trap: begin
				dec_jump       = 1'b1;
				dec_we         = 1'b1;
				dec_dest       = `LC3B_LINK_REG;
				dec_result_sel = 2'd2;
				dec_target_sel = 2'd2;
			end
			default: ; // Loads, stores, RTI and the rest retire as no-ops
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_valid      <= 1'b0;
			ex_valid      <= 1'b0;
			ex_we         <= 1'b0;
			ex_cc_we      <= 1'b0;
			ex_branch     <= 1'b0;
			ex_jump       <= 1'b0;
			ex_aluop      <= alu_pass;
			sr2mux_sel    <= 1'b0;
			result_sel    <= 2'd0;
			target_sel    <= 2'd0;
			bradd2mux_sel <= 1'b0;
			ex_mask       <= '0;
			ex_dest       <= '0;
			ex_src1       <= '0;
			ex_src2       <= '0;
		end else begin
			id_valid      <= in_valid;
			ex_valid      <= id_valid;
			ex_we         <= id_valid & dec_we;
			ex_cc_we      <= id_valid & dec_cc_we;
			ex_branch     <= id_valid & dec_branch;
			ex_jump       <= id_valid & dec_jump;
			ex_aluop      <= dec_aluop;
			sr2mux_sel    <= dec_sr2mux_sel;
			result_sel    <= dec_result_sel;
			target_sel    <= dec_target_sel;
			bradd2mux_sel <= dec_bradd2_sel;
			ex_mask       <= id_instr[11:9];
			ex_dest       <= dec_dest;
			ex_src1       <= id_instr[8:6];
			ex_src2       <= id_instr[2:0];
		end
	end

	// WB copy of what wb_stage holds, for forwarding and the CC update
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
			wb_we    <= 1'b0;
			wb_cc_we <= 1'b0;
			wb_dest  <= '0;
			cc_reg   <= `LC3B_RESET_CC;
		end else begin
			wb_valid <= ex_valid;
			wb_we    <= ex_we;
			wb_cc_we <= ex_cc_we;
			wb_dest  <= ex_dest;
			if (wb_valid && wb_cc_we)
				cc_reg <= gen_cc(write_data);
		end
	end

	assign sr1_forward_sel = wb_valid & wb_we & (wb_dest == ex_src1);
	assign sr2_forward_sel = wb_valid & wb_we & (wb_dest == ex_src2);

	assign cc_ex    = (wb_valid && wb_cc_we) ? gen_cc(write_data) : cc_reg;
	assign ex_taken = ex_valid & (ex_jump | (ex_branch & |(ex_mask & cc_ex)));

endmodule : pipe_control

`default_nettype wire

//--- logic/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  we,
	input  lc3b_types::lc3b_reg   dest,
	input  lc3b_types::lc3b_word  data,
	input  lc3b_types::lc3b_reg   src_a,
	input  lc3b_types::lc3b_reg   src_b,
	output lc3b_types::lc3b_word  out_a,
	output lc3b_types::lc3b_word  out_b
);
	import lc3b_types::*;

	lc3b_word regs [8];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[dest] <= data;
		end
	end

	// A write in the same cycle shows up on the read port at once
	assign out_a = (we && dest == src_a) ? data : regs[src_a];
	assign out_b = (we && dest == src_b) ? data : regs[src_b];

endmodule : regfile

`default_nettype wire

//--- logic/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 ex_valid,
	input  logic                 ex_we,
	input  lc3b_types::lc3b_reg  ex_dest,
	input  logic                 ex_taken,
	input  lc3b_types::lc3b_word result,
	input  lc3b_types::lc3b_word target,
	output lc3b_types::lc3b_word write_data,
	output logic                 res_valid,
	output logic                 res_we,
	output lc3b_types::lc3b_reg  res_dest,
	output lc3b_types::lc3b_word res_data,
	output lc3b_types::lc3b_word res_target,
	output logic                 res_taken
);
	import lc3b_types::*;

	lc3b_word wb_data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
			res_we    <= 1'b0;
			res_taken <= 1'b0;
		end else begin
			res_valid <= ex_valid;
			res_we    <= ex_valid & ex_we;
			res_taken <= ex_valid & ex_taken;
		end
	end

	always_ff @(posedge clk) begin
		res_dest   <= ex_dest;
		wb_data    <= result;
		res_target <= target;
	end

	assign write_data = wb_data; // Also the forwarding source
	assign res_data   = wb_data;

endmodule : wb_stage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the LC-3b pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lc3b_pipe_tb -f verilog.f -o lc3b_pipe_sim

./obj_dir/lc3b_pipe_sim > sim.log 2>&1
cat sim.log

if grep -qx "all tests passed" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

//--- tb/lc3b_pipe_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_cfg.svh"

module lc3b_pipe_assert (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic res_valid,
	input logic res_we,
	input logic res_taken
);

	// No stalls, so every accepted instruction retires a fixed depth later
	a_latency: assert property (@(posedge clk) disable iff (!arst_n)
		res_valid == $past(in_valid, `LC3B_PIPE_DEPTH))
		else $error("res_valid does not follow in_valid by the pipeline depth");

	a_strobes: assert property (@(posedge clk) disable iff (!arst_n)
		(res_we || res_taken) |-> res_valid)
		else $error("res_we or res_taken high without res_valid");

	a_reset: assert property (@(posedge clk) $rose(arst_n) |-> !res_valid)
		else $error("res_valid high right after reset");

endmodule : lc3b_pipe_assert

bind lc3b_pipe lc3b_pipe_assert i_assert (
	.clk       (clk),
	.arst_n    (arst_n),
	.in_valid  (in_valid),
	.res_valid (res_valid),
	.res_we    (res_we),
	.res_taken (res_taken)
);

`default_nettype wire

//--- tb/lc3b_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_cfg.svh"

module lc3b_pipe_tb;
	import lc3b_types::*;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 10;
	localparam int N_INSTR      = 200;
	localparam int NUM_TESTS    = 5;
	// Test 5 may idle up to three cycles before each instruction
	localparam int MAX_CYCLES   = NUM_TESTS * (RESET_CYCLES + 4 * N_INSTR + 20) + 100;

	logic     clk = 1'b0;
	logic     arst_n;
	logic     in_valid;
	lc3b_word in_instr;
	lc3b_word in_pc;
	logic     res_valid;
	logic     res_we;
	lc3b_reg  res_dest;
	lc3b_word res_data;
	lc3b_word res_target;
	logic     res_taken;

	logic [31:0] lfsr = 32'd98350;
	int          cyc = 0;
	int          errors = 0;
	int          checks = 0;
	int          retired = 0;
	lc3b_word    pc_ctr;
	lc3b_reg     last_dest = '0;
	lc3b_reg     prev_dest = '0;

	lc3b_word model_rf [8];
	lc3b_nzp  model_cc;

	int       exp_due [$];
	lc3b_word exp_instr [$];
	logic     exp_we [$];
	lc3b_reg  exp_dest [$];
	lc3b_word exp_data [$];
	logic     exp_taken [$];
	lc3b_word exp_target [$];

	lc3b_pipe i_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.in_pc      (in_pc),
		.res_valid  (res_valid),
		.res_we     (res_we),
		.res_dest   (res_dest),
		.res_data   (res_data),
		.res_target (res_target),
		.res_taken  (res_taken)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[14:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic lc3b_word sext(input lc3b_word v, input int bits);
		lc3b_word s;
		s = v;
		for (int i = bits; i < 16; i++)
			s[i] = v[bits - 1];
		return s;
	endfunction

	function automatic lc3b_opcode pick_opcode(input int test, input int idx);
		logic [31:0] mix;
		logic [15:0] r;
		if (test == 3 && idx < 3)
			return op_br; // These still see the reset condition codes
		r = rand_bits((test == 5) ? 4 : 3);
		case (test)
			1: mix = {op_add, op_and, op_not, op_add, op_and, op_add, op_and, op_not};
			2: mix = {op_shf, op_shf, op_shf, op_shf, op_shf, op_shf, op_add, op_not};
			3: mix = {op_br, op_br, op_br, op_lea, op_add, op_and, op_not, op_lea};
			4: mix = {op_jmp, op_jsr, op_jsr, op_trap, op_br, op_add, op_not, op_jsr};
			default: return lc3b_opcode'(r[3:0]); // Any opcode including loads, stores and RTI
		endcase
		return lc3b_opcode'(mix[r[2:0] * 4 +: 4]);
	endfunction

	task automatic log_error(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	// Executes one instruction in program order and queues what WB must show
	task automatic model_issue(input lc3b_word instr, input lc3b_word pc, input int due);
		lc3b_opcode op;
		lc3b_word   a;
		lc3b_word   b;
		lc3b_word   res;
		lc3b_word   tgt;
		lc3b_reg    dest;
		logic       we;
		logic       taken;
		logic       set_cc;
		op   = lc3b_opcode'(instr[15:12]);
		a    = model_rf[instr[8:6]];
		b    = instr[5] ? sext(lc3b_word'(instr[4:0]), 5) : model_rf[instr[2:0]];
		res  = '0;
		tgt  = '0;
		dest = instr[11:9];
		case (op)
			op_add:  res = a + b;
			op_and:  res = a & b;
			op_not:  res = ~a;
			op_shf: begin
				res = instr[4] ? (a << instr[3:0]) : (a >> instr[3:0]);
				// Arithmetic right shift fills the vacated top bits with the sign
				if (!instr[4] && instr[5] && a[15])
					res = res | ~(16'hFFFF >> instr[3:0]);
			end
			op_lea:  res = pc + (sext(lc3b_word'(instr[8:0]), 9) << 1);
			op_br:   tgt = pc + (sext(lc3b_word'(instr[8:0]), 9) << 1);
			op_jmp:  tgt = a;
			op_jsr:  tgt = instr[11] ? pc + (sext(lc3b_word'(instr[10:0]), 11) << 1) : a;
			op_trap: tgt = lc3b_word'(instr[7:0]) << 1;
			default: ;
		endcase
		set_cc = op inside {op_add, op_and, op_not, op_shf, op_lea};
		if (op inside {op_jsr, op_trap}) begin
			res  = pc;
			dest = `LC3B_LINK_REG;
		end
		we    = set_cc || (op inside {op_jsr, op_trap});
		taken = (op inside {op_jmp, op_jsr, op_trap}) || (op == op_br && |(instr[11:9] & model_cc));
		if (we)
			model_rf[dest] = res;
		if (set_cc)
			model_cc = res[15] ? 3'b100 : ((res == '0) ? 3'b010 : 3'b001);
		exp_due.push_back(due);
		exp_instr.push_back(instr);
		exp_we.push_back(we);
		exp_dest.push_back(dest);
		exp_data.push_back(res);
		exp_taken.push_back(taken);
		exp_target.push_back(tgt);
	endtask

	task automatic drop_expected();
		void'(exp_due.pop_front());
		void'(exp_instr.pop_front());
		void'(exp_we.pop_front());
		void'(exp_dest.pop_front());
		void'(exp_data.pop_front());
		void'(exp_taken.pop_front());
		void'(exp_target.pop_front());
	endtask

	// Scoreboard samples the result ports away from the rising edge
	always @(negedge clk) begin
		if (arst_n && res_valid) begin
			retired++;
			if (exp_due.size() == 0) begin
				log_error($sformatf("Result retired at cycle %0d with nothing outstanding", cyc));
			end else begin
				checks++;
				if (exp_due[0] != cyc)
					log_error($sformatf("Instruction %h retired at cycle %0d instead of %0d",
						exp_instr[0], cyc, exp_due[0]));
				if (res_we !== exp_we[0])
					log_error($sformatf("MISMATCH res_we: got %h expected %h for instr %h",
						res_we, exp_we[0], exp_instr[0]));
				if (exp_we[0] && res_dest !== exp_dest[0])
					log_error($sformatf("MISMATCH res_dest: got %h expected %h for instr %h",
						res_dest, exp_dest[0], exp_instr[0]));
				if (exp_we[0] && res_data !== exp_data[0])
					log_error($sformatf("MISMATCH res_data: got %h expected %h for instr %h",
						res_data, exp_data[0], exp_instr[0]));
				if (res_taken !== exp_taken[0])
					log_error($sformatf("MISMATCH res_taken: got %h expected %h for instr %h",
						res_taken, exp_taken[0], exp_instr[0]));
				if (exp_taken[0] && res_target !== exp_target[0])
					log_error($sformatf("MISMATCH res_target: got %h expected %h for instr %h",
						res_target, exp_target[0], exp_instr[0]));
				drop_expected();
			end
		end else if (arst_n && exp_due.size() != 0 && exp_due[0] < cyc) begin
			log_error($sformatf("Instruction %h never retired, it was due at cycle %0d",
				exp_instr[0], exp_due[0]));
			drop_expected();
		end
	end

	task automatic apply_reset();
		arst_n   <= 1'b0;
		in_valid <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		for (int i = 0; i < 8; i++)
			model_rf[i] = '0;
		model_cc  = `LC3B_RESET_CC;
		last_dest = '0;
		prev_dest = '0;
	endtask

	task automatic run_test(input int test, input string name);
		int          start_errors;
		int          start_retired;
		int          issued;
		logic [15:0] r;
		lc3b_word    instr;
		start_errors  = errors;
		start_retired = retired;
		issued        = 0;
		apply_reset();
		r      = rand_bits(15);
		pc_ctr = {r[14:0], 1'b0};
		for (int i = 0; i < N_INSTR; i++) begin
			if (test == 5) begin
				r = rand_bits(2);
				repeat (r[1:0]) begin
					@(posedge clk);
					in_valid <= 1'b0;
				end
			end
			r     = rand_bits(12);
			instr = {pick_opcode(test, i), r[11:0]};
			// Sources lean on the last two destinations to hit forwarding and write-through
			r = rand_bits(2);
			if (r[0])
				instr[8:6] = last_dest;
			if (r[1])
				instr[2:0] = prev_dest;
			prev_dest = last_dest;
			last_dest = instr[11:9];
			@(posedge clk);
			in_valid <= 1'b1;
			in_instr <= instr;
			in_pc    <= pc_ctr;
			model_issue(instr, pc_ctr, cyc + `LC3B_PIPE_DEPTH + 1);
			pc_ctr = pc_ctr + 16'd2;
			issued++;
		end
		@(posedge clk);
		in_valid <= 1'b0;
		while (exp_due.size() != 0)
			@(posedge clk);
		repeat (`LC3B_PIPE_DEPTH) @(posedge clk); // Catch any extra result
		if ((retired - start_retired) != issued)
			log_error($sformatf("Test %0d retired %0d results for %0d issued instructions",
				test, retired - start_retired, issued));
		$display("Test %0d (%s): %0d issued, %0d errors", test, name, issued,
			errors - start_errors);
	endtask

	initial begin
		arst_n   = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		in_pc    = '0;
		run_test(1, "alu ops with forwarding");
		run_test(2, "shifts");
		run_test(3, "lea and branches");
		run_test(4, "jumps, subroutines and traps");
		run_test(5, "idle gaps and no-op opcodes");
		$display("Results checked: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		#(MAX_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles without the tests finishing", MAX_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule : lc3b_pipe_tb

`default_nettype wire

//--- verilog.f
+incdir+logic
logic/lc3b_types.sv
logic/regfile.sv
logic/alu.sv
logic/execute_stage.sv
logic/id_stage.sv
logic/pipe_control.sv
logic/wb_stage.sv
logic/lc3b_pipe.sv
tb/lc3b_pipe_assert.sv
tb/lc3b_pipe_tb.sv
